// File: logic/media_pkg.sv
package media_pkg;

	localparam int word_width = 128;
	localparam int instr_width = 25;
	localparam int reg_addr_width = 5;
	localparam int reg_count = 32;
	localparam int imm_width = 16;
	localparam int lane_sel_width = 3;

	typedef logic [word_width-1:0] word_t;
	typedef logic [instr_width-1:0] instr_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;
	typedef logic [imm_width-1:0] imm_t;
	typedef logic [lane_sel_width-1:0] lane_sel_t;

	// instruction field positions (lsb of each field)
	localparam int rd_lsb = 0;
	localparam int rs1_lsb = 5;
	localparam int rs2_lsb = 10;
	localparam int rs3_lsb = 15;
	localparam int r4_op_lsb = 20;
	localparam int r4_op_width = 3;
	localparam int r3_op_lsb = 15;
	localparam int r3_op_width = 4;
	localparam int imm_lsb = 5;
	localparam int lane_lsb = 21;
	// bit 24 alone for load-immediate, bits 24..23 for R4/R3
	localparam int fmt_bit = 24;

	typedef enum logic [3:0] {
		op_load_imm,
		op_mac_low,
		op_mac_high,
		op_msub_low,
		op_msub_high,
		op_nop,
		op_add_word,
		op_absdiff_byte,
		op_sat_add_half,
		op_and,
		op_or,
		op_max_word,
		op_popcount_word,
		op_rotate_word,
		op_sat_sub_half,
		op_sub_word
	} alu_op_e;

	// R3 format, opcode 0
	localparam instr_t nop_instr = {2'b11, {(instr_width-2){1'b0}}};

endpackage

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
	import media_pkg::*;
#(
	parameter int prog_depth = 64
) (
	input logic clk,
	input logic reset,
	input instr_t program_mem [prog_depth],
	output logic [$clog2(prog_depth)-1:0] pc,
	output instr_t instruction
);

	localparam int pc_width = $clog2(prog_depth);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			instruction <= nop_instr;
		end else begin
			instruction <= program_mem[pc];
			// wrap at the last program word
			if (pc == pc_width'(prog_depth - 1)) begin
				pc <= '0;
			end else begin
				pc <= pc + 1'b1;
			end
		end
	end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file
	import media_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wr_en,
	input reg_addr_t wr_addr,
	input word_t wr_data,
	input reg_addr_t rd_addr_a,
	input reg_addr_t rd_addr_b,
	input reg_addr_t rd_addr_c,
	input reg_addr_t rd_addr_d,
	output word_t rd_data_a,
	output word_t rd_data_b,
	output word_t rd_data_c,
	output word_t rd_data_d
);

	word_t regs [reg_count];

	// write-first: a read of the register being written sees the new value
	function automatic word_t read_port(input reg_addr_t addr);
		if (wr_en && addr == wr_addr) begin
			return wr_data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
		rd_data_c = read_port(rd_addr_c);
		rd_data_d = read_port(rd_addr_d);
	end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
	import media_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_t instruction,
	input logic wb_wr_en,
	input reg_addr_t wb_rd,
	input word_t wb_result,
	output word_t rs1_value,
	output word_t rs2_value,
	output word_t rs3_value,
	output word_t rd_value,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	output reg_addr_t rs3_addr,
	output reg_addr_t id_rd,
	output logic id_wr_en,
	output alu_op_e alu_op,
	output lane_sel_t lane_sel,
	output imm_t imm
);

	reg_addr_t rs1_field;
	reg_addr_t rs2_field;
	reg_addr_t rs3_field;
	reg_addr_t rd_field;
	word_t rs1_read;
	word_t rs2_read;
	word_t rs3_read;
	word_t rd_read;
	alu_op_e dec_op;

	assign rs1_field = instruction[rs1_lsb +: reg_addr_width];
	assign rs2_field = instruction[rs2_lsb +: reg_addr_width];
	assign rs3_field = instruction[rs3_lsb +: reg_addr_width];
	assign rd_field = instruction[rd_lsb +: reg_addr_width];

	register_file regfile_i (
		.clk(clk),
		.reset(reset),
		.wr_en(wb_wr_en),
		.wr_addr(wb_rd),
		.wr_data(wb_result),
		.rd_addr_a(rs1_field),
		.rd_addr_b(rs2_field),
		.rd_addr_c(rs3_field),
		.rd_addr_d(rd_field),
		.rd_data_a(rs1_read),
		.rd_data_b(rs2_read),
		.rd_data_c(rs3_read),
		.rd_data_d(rd_read)
	);

	// dropped codes fall through to nop
	always_comb begin
		dec_op = op_nop;
		if (!instruction[fmt_bit]) begin
			dec_op = op_load_imm;
		end else if (instruction[fmt_bit -: 2] == 2'b10) begin
			case (instruction[r4_op_lsb +: r4_op_width])
				3'd0: dec_op = op_mac_low;
				3'd1: dec_op = op_mac_high;
				3'd2: dec_op = op_msub_low;
				3'd3: dec_op = op_msub_high;
				default: dec_op = op_nop;
			endcase
		end else begin
			case (instruction[r3_op_lsb +: r3_op_width])
				4'd1: dec_op = op_add_word;
				4'd2: dec_op = op_absdiff_byte;
				4'd4: dec_op = op_sat_add_half;
				4'd5: dec_op = op_and;
				4'd7: dec_op = op_max_word;
				4'd11: dec_op = op_or;
				4'd12: dec_op = op_popcount_word;
				4'd13: dec_op = op_rotate_word;
				4'd14: dec_op = op_sat_sub_half;
				4'd15: dec_op = op_sub_word;
				default: dec_op = op_nop;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			id_wr_en <= 1'b0;
			alu_op <= op_nop;
		end else begin
			id_wr_en <= (dec_op != op_nop);
			alu_op <= dec_op;
		end
	end

	always_ff @(posedge clk) begin
		rs1_value <= rs1_read;
		rs2_value <= rs2_read;
		rs3_value <= rs3_read;
		rd_value <= rd_read;
		rs1_addr <= rs1_field;
		rs2_addr <= rs2_field;
		rs3_addr <= rs3_field;
		id_rd <= rd_field;
		lane_sel <= instruction[lane_lsb +: lane_sel_width];
		imm <= instruction[imm_lsb +: imm_width];
	end

endmodule

// File: logic/forward_unit.sv
`timescale 1ns/1ps

module forward_unit
	import media_pkg::*;
(
	input alu_op_e alu_op,
	input reg_addr_t rs1_addr,
	input reg_addr_t rs2_addr,
	input reg_addr_t rs3_addr,
	input reg_addr_t id_rd,
	input word_t rs1_value,
	input word_t rs2_value,
	input word_t rs3_value,
	input word_t rd_value,
	input logic wb_wr_en,
	input reg_addr_t wb_rd,
	input word_t wb_result,
	output word_t src1,
	output word_t src2,
	output word_t src3,
	output word_t old_rd
);

	logic is_load;
	logic fwd_rs1;
	logic fwd_rs2;
	logic fwd_rs3;
	logic fwd_rd;

	// load-immediate only needs the old rd, the others only the sources
	assign is_load = (alu_op == op_load_imm);

	assign fwd_rs1 = wb_wr_en && !is_load && (rs1_addr == wb_rd);
	assign fwd_rs2 = wb_wr_en && !is_load && (rs2_addr == wb_rd);
	assign fwd_rs3 = wb_wr_en && !is_load && (rs3_addr == wb_rd);
	assign fwd_rd = wb_wr_en && is_load && (id_rd == wb_rd);

	assign src1 = fwd_rs1 ? wb_result : rs1_value;
	assign src2 = fwd_rs2 ? wb_result : rs2_value;
	assign src3 = fwd_rs3 ? wb_result : rs3_value;
	assign old_rd = fwd_rd ? wb_result : rd_value;

endmodule

// File: logic/media_alu.sv
`timescale 1ns/1ps

module media_alu
	import media_pkg::*;
(
	input alu_op_e alu_op,
	input word_t src1,
	input word_t src2,
	input word_t src3,
	input word_t old_rd,
	input lane_sel_t lane_sel,
	input imm_t imm,
	output word_t result
);

	logic mac_hi;
	logic mac_sub;

	// acc +/- a*b, clamped to signed 32 bits
	function automatic logic [31:0] mac_lane(
		input logic [31:0] acc,
		input logic [15:0] a,
		input logic [15:0] b,
		input logic sub
	);
		logic signed [33:0] prod;
		logic signed [33:0] sum;
		prod = $signed(a) * $signed(b);
		if (sub) begin
			sum = $signed(acc) - prod;
		end else begin
			sum = $signed(acc) + prod;
		end
		if (sum > 34'sd2147483647) begin
			return 32'h7fff_ffff;
		end else if (sum < -34'sd2147483648) begin
			return 32'h8000_0000;
		end
		return sum[31:0];
	endfunction

	// x +/- y on signed halfwords with saturation
	function automatic logic [15:0] sat_half(
		input logic [15:0] x,
		input logic [15:0] y,
		input logic sub
	);
		logic signed [16:0] s;
		if (sub) begin
			s = $signed(x) - $signed(y);
		end else begin
			s = $signed(x) + $signed(y);
		end
		if (s > 17'sd32767) begin
			return 16'h7fff;
		end else if (s < -17'sd32768) begin
			return 16'h8000;
		end
		return s[15:0];
	endfunction

	function automatic logic [31:0] rotr32(input logic [31:0] x, input logic [4:0] amt);
		logic [63:0] pair;
		pair = {x, x} >> amt;
		return pair[31:0];
	endfunction

	function automatic logic [7:0] absdiff8(input logic [7:0] a, input logic [7:0] b);
		if (a > b) begin
			return a - b;
		end
		return b - a;
	endfunction

	assign mac_hi = (alu_op == op_mac_high) || (alu_op == op_msub_high);
	assign mac_sub = (alu_op == op_msub_low) || (alu_op == op_msub_high);

	always_comb begin
		result = '0;
		case (alu_op)
			op_load_imm: begin
				result = old_rd;
				result[lane_sel * imm_width +: imm_width] = imm;
			end
			op_mac_low, op_mac_high, op_msub_low, op_msub_high: begin
				// src3 * src2 on the low or high halfword of each word
				for (int w = 0; w < 4; w++) begin
					result[32*w +: 32] = mac_lane(src1[32*w +: 32],
						src3[32*w + 16*mac_hi +: 16],
						src2[32*w + 16*mac_hi +: 16], mac_sub);
				end
			end
			op_add_word: begin
				for (int w = 0; w < 4; w++) begin
					result[32*w +: 32] = src1[32*w +: 32] + src2[32*w +: 32];
				end
			end
			op_absdiff_byte: begin
				for (int b = 0; b < 16; b++) begin
					result[8*b +: 8] = absdiff8(src1[8*b +: 8], src2[8*b +: 8]);
				end
			end
			op_sat_add_half: begin
				for (int h = 0; h < 8; h++) begin
					result[16*h +: 16] = sat_half(src1[16*h +: 16], src2[16*h +: 16], 1'b0);
				end
			end
			op_and: result = src1 & src2;
			op_or: result = src1 | src2;
			op_max_word: begin
				for (int w = 0; w < 4; w++) begin
					if ($signed(src1[32*w +: 32]) > $signed(src2[32*w +: 32])) begin
						result[32*w +: 32] = src1[32*w +: 32];
					end else begin
						result[32*w +: 32] = src2[32*w +: 32];
					end
				end
			end
			op_popcount_word: begin
				for (int w = 0; w < 4; w++) begin
					result[32*w +: 32] = 32'($countones(src1[32*w +: 32]));
				end
			end
			op_rotate_word: begin
				for (int w = 0; w < 4; w++) begin
					result[32*w +: 32] = rotr32(src1[32*w +: 32], src2[32*w +: 5]);
				end
			end
			op_sat_sub_half: begin
				// note the operand order, rs2 minus rs1
				for (int h = 0; h < 8; h++) begin
					result[16*h +: 16] = sat_half(src2[16*h +: 16], src1[16*h +: 16], 1'b1);
				end
			end
			op_sub_word: begin
				for (int w = 0; w < 4; w++) begin
					result[32*w +: 32] = src2[32*w +: 32] - src1[32*w +: 32];
				end
			end
			default: result = '0;
		endcase
	end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
	import media_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t rs1_value,
	input word_t rs2_value,
	input word_t rs3_value,
	input word_t rd_value,
	input reg_addr_t rs1_addr,
	input reg_addr_t rs2_addr,
	input reg_addr_t rs3_addr,
	input reg_addr_t id_rd,
	input logic id_wr_en,
	input alu_op_e alu_op,
	input lane_sel_t lane_sel,
	input imm_t imm,
	output logic wb_wr_en,
	output reg_addr_t wb_rd,
	output word_t wb_result
);

	word_t src1;
	word_t src2;
	word_t src3;
	word_t old_rd;
	word_t alu_result;

	forward_unit forward_i (
		.alu_op(alu_op),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs3_addr(rs3_addr),
		.id_rd(id_rd),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.rs3_value(rs3_value),
		.rd_value(rd_value),
		.wb_wr_en(wb_wr_en),
		.wb_rd(wb_rd),
		.wb_result(wb_result),
		.src1(src1),
		.src2(src2),
		.src3(src3),
		.old_rd(old_rd)
	);

	media_alu alu_i (
		.alu_op(alu_op),
		.src1(src1),
		.src2(src2),
		.src3(src3),
		.old_rd(old_rd),
		.lane_sel(lane_sel),
		.imm(imm),
		.result(alu_result)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_wr_en <= 1'b0;
		end else begin
			wb_wr_en <= id_wr_en;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= id_rd;
		wb_result <= alu_result;
	end

endmodule

// File: logic/media_core.sv
`timescale 1ns/1ps

module media_core
	import media_pkg::*;
#(
	parameter int prog_depth = 64
) (
	input logic clk,
	input logic reset,
	input instr_t program_mem [prog_depth],
	output logic [$clog2(prog_depth)-1:0] pc,
	output logic wb_wr_en,
	output reg_addr_t wb_rd,
	output word_t wb_result
);

	instr_t instruction;
	word_t rs1_value;
	word_t rs2_value;
	word_t rs3_value;
	word_t rd_value;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rs3_addr;
	reg_addr_t id_rd;
	logic id_wr_en;
	alu_op_e alu_op;
	lane_sel_t lane_sel;
	imm_t imm;

	fetch_stage #(
		.prog_depth(prog_depth)
	) fetch_i (
		.clk(clk),
		.reset(reset),
		.program_mem(program_mem),
		.pc(pc),
		.instruction(instruction)
	);

	// write-back is the execute registers looped back to the register file
	decode_stage decode_i (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.wb_wr_en(wb_wr_en),
		.wb_rd(wb_rd),
		.wb_result(wb_result),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.rs3_value(rs3_value),
		.rd_value(rd_value),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs3_addr(rs3_addr),
		.id_rd(id_rd),
		.id_wr_en(id_wr_en),
		.alu_op(alu_op),
		.lane_sel(lane_sel),
		.imm(imm)
	);

	execute_stage execute_i (
		.clk(clk),
		.reset(reset),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.rs3_value(rs3_value),
		.rd_value(rd_value),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs3_addr(rs3_addr),
		.id_rd(id_rd),
		.id_wr_en(id_wr_en),
		.alu_op(alu_op),
		.lane_sel(lane_sel),
		.imm(imm),
		.wb_wr_en(wb_wr_en),
		.wb_rd(wb_rd),
		.wb_result(wb_result)
	);

endmodule

// File: tests/media_checker.sv
`timescale 1ns/1ps

module media_checker
	import media_pkg::*;
#(
	parameter int prog_depth = 64
) (
	input logic clk,
	input logic reset,
	input instr_t program_mem [prog_depth],
	input logic [$clog2(prog_depth)-1:0] pc,
	input logic wb_wr_en,
	input reg_addr_t wb_rd,
	input word_t wb_result,
	output logic done,
	output int error_count,
	output int check_count
);

	word_t model [reg_count];
	logic in_reset = 1'b1;
	int edges = 0;
	int pulse_count;
	int writer_count;

	initial begin
		done = 1'b0;
		error_count = 0;
		check_count = 0;
	end

	task automatic check(input bit ok, input string msg);
		check_count++;
		if (!ok) begin
			error_count++;
			$display("[ERROR] %0t: %s", $time, msg);
		end
	endtask

	function automatic longint saturate(input longint v, input int bits);
		longint top;
		top = (longint'(1) << (bits - 1)) - 1;
		if (v > top) begin
			return top;
		end
		if (v < -top - 1) begin
			return -top - 1;
		end
		return v;
	endfunction

	// expected write-back of one instruction and whether it writes at all
	function automatic bit expected_write(
		input instr_t ins,
		input word_t s1,
		input word_t s2,
		input word_t s3,
		input word_t old,
		output word_t res
	);
		longint acc;
		longint prod;
		int hi;
		int diff;
		int cnt;
		int lhs;
		int rhs;
		logic [31:0] x;
		res = '0;
		if (ins[24] == 1'b0) begin
			res = old;
			res[16*ins[23:21] +: 16] = ins[20:5];
			return 1'b1;
		end
		if (ins[24:23] == 2'b10) begin
			// sub-ops 4..7 are the long multiplies
			if (ins[22]) begin
				return 1'b0;
			end
			hi = ins[20] ? 16 : 0;
			for (int w = 0; w < 4; w++) begin
				prod = longint'($signed(s3[32*w + hi +: 16]))
					* longint'($signed(s2[32*w + hi +: 16]));
				acc = longint'($signed(s1[32*w +: 32]));
				acc = ins[21] ? acc - prod : acc + prod;
				acc = saturate(acc, 32);
				res[32*w +: 32] = acc[31:0];
			end
			return 1'b1;
		end
		case (ins[18:15])
			4'd1: begin
				for (int w = 0; w < 4; w++) begin
					res[32*w +: 32] = s1[32*w +: 32] + s2[32*w +: 32];
				end
			end
			4'd2: begin
				for (int b = 0; b < 16; b++) begin
					diff = int'(s1[8*b +: 8]) - int'(s2[8*b +: 8]);
					if (diff < 0) begin
						diff = -diff;
					end
					res[8*b +: 8] = diff[7:0];
				end
			end
			4'd4: begin
				for (int h = 0; h < 8; h++) begin
					acc = longint'($signed(s1[16*h +: 16])) + longint'($signed(s2[16*h +: 16]));
					acc = saturate(acc, 16);
					res[16*h +: 16] = acc[15:0];
				end
			end
			4'd5: res = s1 & s2;
			4'd11: res = s1 | s2;
			4'd7: begin
				for (int w = 0; w < 4; w++) begin
					lhs = int'(s1[32*w +: 32]);
					rhs = int'(s2[32*w +: 32]);
					res[32*w +: 32] = (lhs > rhs) ? lhs : rhs;
				end
			end
			4'd12: begin
				for (int w = 0; w < 4; w++) begin
					cnt = 0;
					for (int k = 0; k < 32; k++) begin
						cnt += s1[32*w + k];
					end
					res[32*w +: 32] = cnt;
				end
			end
			4'd13: begin
				// one bit at a time
				for (int w = 0; w < 4; w++) begin
					x = s1[32*w +: 32];
					for (int r = 0; r < int'(s2[32*w +: 5]); r++) begin
						x = {x[0], x[31:1]};
					end
					res[32*w +: 32] = x;
				end
			end
			4'd14: begin
				for (int h = 0; h < 8; h++) begin
					acc = longint'($signed(s2[16*h +: 16])) - longint'($signed(s1[16*h +: 16]));
					acc = saturate(acc, 16);
					res[16*h +: 16] = acc[15:0];
				end
			end
			4'd15: begin
				for (int w = 0; w < 4; w++) begin
					res[32*w +: 32] = s2[32*w +: 32] - s1[32*w +: 32];
				end
			end
			default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	always @(posedge clk) begin
		in_reset <= reset;
		if (reset) begin
			edges <= 0;
		end else begin
			edges <= edges + 1;
		end
	end

	// word n reaches write-back on edge n+3 after reset
	always @(negedge clk) begin
		int slot;
		bit writes;
		instr_t ins;
		word_t expected;
		if (in_reset) begin
			for (int i = 0; i < reg_count; i++) begin
				model[i] = '0;
			end
			pulse_count = 0;
			writer_count = 0;
			check(pc === '0, "pc is not 0 during reset");
			check(wb_wr_en === 1'b0, "wb_wr_en is set during reset");
		end else if (!done) begin
			slot = edges - 3;
			check(int'(pc) == edges % prog_depth,
				$sformatf("pc %0d, expected %0d", pc, edges % prog_depth));
			if (wb_wr_en === 1'b1) begin
				pulse_count++;
			end
			if (slot < 0) begin
				check(wb_wr_en === 1'b0, "wb_wr_en set before the first word reached write-back");
			end else begin
				ins = program_mem[slot];
				writes = expected_write(ins, model[ins[9:5]], model[ins[14:10]],
					model[ins[19:15]], model[ins[4:0]], expected);
				if (writes) begin
					writer_count++;
					check(wb_wr_en === 1'b1, $sformatf("no write-back for word %0d", slot));
					check(wb_rd === ins[4:0],
						$sformatf("word %0d wb_rd %0d, expected %0d", slot, wb_rd, ins[4:0]));
					check(wb_result === expected,
						$sformatf("word %0d wb_result %h, expected %h", slot, wb_result, expected));
					model[ins[4:0]] = expected;
				end else begin
					check(wb_wr_en === 1'b0, $sformatf("unexpected write-back for word %0d", slot));
				end
				if (slot == prog_depth - 1) begin
					check(pulse_count == writer_count,
						$sformatf("%0d write-back pulses, expected %0d", pulse_count, writer_count));
					done = 1'b1;
				end
			end
		end
	end

endmodule

// File: tests/media_core_tb.sv
`timescale 1ns/1ps

module media_core_tb
	import media_pkg::*;
#(
	parameter int prog_depth = 64
);

	localparam int pc_width = $clog2(prog_depth);
	localparam int timeout_cycles = prog_depth + 32;

	logic clk = 1'b0;
	logic reset;
	instr_t program_mem [prog_depth];
	logic [pc_width-1:0] pc;
	logic wb_wr_en;
	reg_addr_t wb_rd;
	word_t wb_result;
	logic done;
	int error_count;
	int check_count;
	int cycles;

	always #20 clk = ~clk;

	function automatic instr_t load_imm_instr(input int rd, input int lane, input imm_t value);
		return {1'b0, 3'(lane), value, 5'(rd)};
	endfunction

	function automatic instr_t r4_instr(
		input int sub,
		input int rs3,
		input int rs2,
		input int rs1,
		input int rd
	);
		return {2'b10, 3'(sub), 5'(rs3), 5'(rs2), 5'(rs1), 5'(rd)};
	endfunction

	function automatic instr_t r3_instr(input int op, input int rs2, input int rs1, input int rd);
		return {2'b11, 4'b0000, 4'(op), 5'(rs2), 5'(rs1), 5'(rd)};
	endfunction

	// small register set to make hazards frequent
	task automatic build_program();
		int kind;
		int op;
		for (int i = 0; i < prog_depth; i++) begin
			if (i < 8) begin
				// r6 gets 0x7fff in every lane
				program_mem[i] = load_imm_instr(6, i, 16'h7fff);
			end else if (i < 16) begin
				// r7 gets 0x8000 in every lane
				program_mem[i] = load_imm_instr(7, i - 8, 16'h8000);
			end else if (i < 32) begin
				program_mem[i] = load_imm_instr(i % 6, $urandom % 8, imm_t'($urandom));
			end else if (i < 38) begin
				// saturating cases on the extreme registers
				case (i)
					32: program_mem[i] = r4_instr(0, 6, 6, 6, 1);
					33: program_mem[i] = r4_instr(1, 7, 7, 6, 2);
					34: program_mem[i] = r4_instr(2, 6, 6, 7, 3);
					35: program_mem[i] = r4_instr(3, 7, 7, 7, 4);
					36: program_mem[i] = r3_instr(4, 6, 6, 5);
					default: program_mem[i] = r3_instr(14, 7, 6, 0);
				endcase
			end else if (i < 46) begin
				// each remaining kept R3 op once
				case (i)
					38: op = 1;
					39: op = 2;
					40: op = 5;
					41: op = 7;
					42: op = 11;
					43: op = 12;
					44: op = 13;
					default: op = 15;
				endcase
				program_mem[i] = r3_instr(op, $urandom % 8, $urandom % 8, $urandom % 8);
			end else begin
				kind = $urandom % 8;
				if (kind == 0) begin
					program_mem[i] = load_imm_instr($urandom % 8, $urandom % 8,
						imm_t'($urandom));
				end else if (kind < 3) begin
					program_mem[i] = r4_instr($urandom % 8, $urandom % 8, $urandom % 8,
						$urandom % 8, $urandom % 8);
				end else begin
					program_mem[i] = r3_instr($urandom % 16, $urandom % 8, $urandom % 8,
						$urandom % 8);
				end
			end
		end
	endtask

	media_core #(
		.prog_depth(prog_depth)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.program_mem(program_mem),
		.pc(pc),
		.wb_wr_en(wb_wr_en),
		.wb_rd(wb_rd),
		.wb_result(wb_result)
	);

	media_checker #(
		.prog_depth(prog_depth)
	) checker_i (
		.clk(clk),
		.reset(reset),
		.program_mem(program_mem),
		.pc(pc),
		.wb_wr_en(wb_wr_en),
		.wb_rd(wb_rd),
		.wb_result(wb_result),
		.done(done),
		.error_count(error_count),
		.check_count(check_count)
	);

	initial begin
		void'($urandom(32'h2863_115e));
		reset = 1'b1;
		build_program();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (!done && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: the checker did not reach the last program word in %0d cycles",
				timeout_cycles);
		end
		$display("checker: %0d checks, %0d errors", check_count, error_count);
		if (done && error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: sim.f
logic/media_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/forward_unit.sv
logic/media_alu.sv
logic/execute_stage.sv
logic/media_core.sv
tests/media_checker.sv
tests/media_core_tb.sv

// File: Bender.yml
package:
  name: media_core

sources:
  - files:
      - logic/media_pkg.sv
      - logic/fetch_stage.sv
      - logic/register_file.sv
      - logic/decode_stage.sv
      - logic/forward_unit.sv
      - logic/media_alu.sv
      - logic/execute_stage.sv
      - logic/media_core.sv
  - target: test
    files:
      - tests/media_checker.sv
      - tests/media_core_tb.sv
